/* list.f */
src/capi_cmd_pkg.sv
src/parity.sv
src/cmd_apb_regs.sv
src/cmd_stream_gen.sv
src/cmd_arbiter.sv
src/cmd_issue.sv
src/cmd_issue_top.sv
verif/tb_cmd_issue.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_cmd_issue -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  exit 1
fi
exit 0

/* verif/tb_cmd_issue.sv */
// self-checking testbench top for the command issue path; compiled from list.f and run by run.sh
`timescale 1ns/1ps

module tb_cmd_issue;

  import capi_cmd_pkg::*;

  logic                   clock;
  logic                   rstn;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [7:0]             paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   cmd_valid;
  logic [cmd_width-1:0]   cmd_command;
  logic                   cmd_command_parity;
  logic [addr_width-1:0]  cmd_address;
  logic                   cmd_address_parity;
  logic [tag_width-1:0]   cmd_tag;
  logic                   cmd_tag_parity;
  logic [size_width-1:0]  cmd_size;
  logic [abt_width-1:0]   cmd_abt;
  logic [ctx_width-1:0]   cmd_context_handle;
  logic                   rsp_valid;
  logic [tag_width-1:0]   rsp_tag;

  // reference model state
  logic [63:0]            rd_exp[$];
  logic [63:0]            wr_exp[$];
  logic [tag_width-1:0]   pend[$];
  logic [tag_count-1:0]   tag_busy = '0;
  logic [cmd_width-1:0]   prev_cmd;
  logic                   both_pending;
  logic                   hold = 1'b0;
  logic                   release_one = 1'b0;
  logic [31:0]            lfsr = 32'h9f50;
  int                     in_flight = 0;
  int                     seen = 0;
  int                     rsp_idx;
  int                     cycles = 0;
  int                     limit = 2000;
  int                     rc;
  int                     wc;
  int                     quiet_mark;

  cmd_issue_top u_dut (
    .clock, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .cmd_valid, .cmd_command, .cmd_command_parity, .cmd_address, .cmd_address_parity,
    .cmd_tag, .cmd_tag_parity, .cmd_size, .cmd_abt, .cmd_context_handle,
    .rsp_valid, .rsp_tag
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random bits and reporting
  ////////////////////////////////////////////////////////////////////////////

  // galois form shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // apb master
  ////////////////////////////////////////////////////////////////////////////

  // setup then access then idle with results sampled mid access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    check("pready", pready, 1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(negedge clock);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] d;
    logic        err;
    apb_access(1'b1, addr, data, d, err);
    check("pslverr", err, 0);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    logic        err;
    apb_access(1'b0, addr, 32'd0, d, err);
    check("pslverr", err, 0);
    check($sformatf("prdata at 0x%02h", addr), d, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host side responder and bus monitor
  ////////////////////////////////////////////////////////////////////////////

  // returns held tags in random order after random delays
  always @(posedge clock) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      if (pend.size() > 0 && (!hold || release_one)) begin
        if (release_one || rand_bits(2) == 0) begin
          rsp_idx = int'(rand_bits(4)) % pend.size();
          rsp_valid <= 1'b1;
          rsp_tag   <= pend[rsp_idx];
          tag_busy[pend[rsp_idx][3:0]] = 1'b0;
          in_flight--;
          pend.delete(rsp_idx);
          release_one = 1'b0;
        end
      end
    end
  end

  // outputs settle by the falling edge
  always @(negedge clock) begin
    if (rstn && cmd_valid) begin
      seen++;
      check("cmd_size", cmd_size, line_bytes);
      check("cmd_abt", cmd_abt, abt_strict);
      check("cmd_context_handle", cmd_context_handle, 0);
      // odd ones count over field plus parity
      check("cmd_tag_parity", $countones({cmd_tag, cmd_tag_parity}) % 2, 1);
      check("cmd_command_parity", $countones({cmd_command, cmd_command_parity}) % 2, 1);
      check("cmd_address_parity", $countones({cmd_address, cmd_address_parity}) % 2, 1);
      if (cmd_tag >= 8'd16) begin
        fail_run("tag outside the 16-entry pool");
      end
      if (tag_busy[cmd_tag[3:0]]) begin
        fail_run("tag reissued before its response returned");
      end
      tag_busy[cmd_tag[3:0]] = 1'b1;
      in_flight++;
      pend.push_back(cmd_tag);
      // round robin only matters while both streams still hold lines
      both_pending = rd_exp.size() > 0 && wr_exp.size() > 0;
      if (both_pending && (prev_cmd == cmd_read_cl_na || prev_cmd == cmd_write_na)) begin
        check("cmd_command", cmd_command,
              (prev_cmd == cmd_read_cl_na) ? cmd_write_na : cmd_read_cl_na);
      end
      if (cmd_command == cmd_read_cl_na) begin
        if (rd_exp.size() == 0) begin
          fail_run("read command beyond the programmed count");
        end
        check("cmd_address", cmd_address, rd_exp.pop_front());
      end else if (cmd_command == cmd_write_na) begin
        if (wr_exp.size() == 0) begin
          fail_run("write command beyond the programmed count");
        end
        check("cmd_address", cmd_address, wr_exp.pop_front());
      end else begin
        check("cmd_command", cmd_command, cmd_read_cl_na);
      end
      prev_cmd = cmd_command;
    end
  end

  // run limit grows with every programmed line
  always @(posedge clock) begin
    cycles++;
    if (cycles > limit) begin
      fail_run($sformatf("timeout, run still busy after %0d cycles", limit));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic register_test();
    logic [7:0]  offs[6];
    logic [31:0] vals[6];
    logic [31:0] d;
    logic        err;
    offs = '{reg_rd_base_lo, reg_rd_base_hi, reg_rd_count,
             reg_wr_base_lo, reg_wr_base_hi, reg_wr_count};
    read_expect(reg_status, 32'h0);
    for (int i = 0; i < 6; i++) begin
      vals[i] = rand_bits(32);
      write_reg(offs[i], vals[i]);
    end
    // counts keep only 16 bits
    for (int i = 0; i < 6; i++) begin
      if (offs[i] == reg_rd_count || offs[i] == reg_wr_count) begin
        read_expect(offs[i], {16'd0, vals[i][15:0]});
      end else begin
        read_expect(offs[i], vals[i]);
      end
    end
    write_reg(reg_ctrl, 32'h1);
    read_expect(reg_ctrl, 32'h1);
    write_reg(reg_ctrl, 32'h0);
    read_expect(reg_ctrl, 32'h0);
    // unmapped offsets
    apb_access(1'b1, 8'h20, rand_bits(32), d, err);
    check("pslverr", err, 1);
    apb_access(1'b0, 8'h20, 32'd0, d, err);
    check("pslverr", err, 1);
    check("prdata", d, 0);
    apb_access(1'b0, 8'h7C, 32'd0, d, err);
    check("pslverr", err, 1);
    check("prdata", d, 0);
    read_expect(reg_rd_base_lo, vals[0]);
  endtask

  // random line-aligned bases with the model filled before the start pulse
  task automatic start_streams(input int rn, input int wn);
    logic [63:0] rb;
    logic [63:0] wb;
    rb = rand_bits(57) << 7;
    wb = rand_bits(57) << 7;
    for (int i = 0; i < rn; i++) begin
      rd_exp.push_back(rb + 64'(i * line_bytes));
    end
    for (int i = 0; i < wn; i++) begin
      wr_exp.push_back(wb + 64'(i * line_bytes));
    end
    limit += 64 * (rn + wn);
    prev_cmd = cmd_touch_i;
    write_reg(reg_rd_base_lo, rb[31:0]);
    write_reg(reg_rd_base_hi, rb[63:32]);
    write_reg(reg_rd_count, 32'(rn));
    write_reg(reg_wr_base_lo, wb[31:0]);
    write_reg(reg_wr_base_hi, wb[63:32]);
    write_reg(reg_wr_count, 32'(wn));
    // enable plus both start bits
    write_reg(reg_ctrl, 32'h7);
  endtask

  task automatic wait_drain();
    while (rd_exp.size() > 0 || wr_exp.size() > 0 || pend.size() > 0) begin
      @(negedge clock);
    end
    read_expect(reg_status, 32'h0);
  endtask

  task automatic stall_test();
    int mark;
    hold = 1'b1;
    rc = 12 + int'(rand_bits(4) % 13);
    wc = 12 + int'(rand_bits(4) % 13);
    start_streams(rc, wc);
    while (in_flight < tag_count) begin
      @(negedge clock);
    end
    mark = seen;
    repeat (40) @(negedge clock);
    check("cmd_valid count", seen, mark);
    // 8 lines gone from each stream and both still busy
    read_expect(reg_status, {19'd0, 5'd16, 6'd0, 2'b11});
    release_one = 1'b1;
    while (seen == mark) begin
      @(negedge clock);
    end
    check("tags in flight", in_flight, tag_count);
    hold = 1'b0;
    wait_drain();
  endtask

  task automatic enable_test();
    int mark;
    mark = seen;
    rc = 12 + int'(rand_bits(4) % 13);
    wc = 12 + int'(rand_bits(4) % 13);
    start_streams(rc, wc);
    while (seen < mark + 4) begin
      @(negedge clock);
    end
    write_reg(reg_ctrl, 32'h0);
    // commands already granted still drain
    repeat (4) @(negedge clock);
    mark = seen;
    repeat (50) @(negedge clock);
    check("cmd_valid count", seen, mark);
    write_reg(reg_ctrl, 32'h1);
    wait_drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rstn      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 8'd0;
    pwdata    = 32'd0;
    rsp_valid = 1'b0;
    rsp_tag   = '0;
    prev_cmd  = cmd_touch_i;
    repeat (16) @(posedge clock);
    rstn <= 1'b1;
    @(negedge clock);
    // idle bus after reset
    check("cmd_valid", cmd_valid, 0);
    check("cmd_command", cmd_command, cmd_touch_i);
    check("cmd_abt", cmd_abt, abt_strict);
    check("cmd_context_handle", cmd_context_handle, 0);
    register_test();
    repeat (4) begin
      rc = 1 + int'(rand_bits(5) % 24);
      wc = 1 + int'(rand_bits(5) % 24);
      start_streams(rc, wc);
      wait_drain();
    end
    stall_test();
    enable_test();
    // nothing extra may trail the last stream
    quiet_mark = seen;
    repeat (20) @(negedge clock);
    check("cmd_valid count", seen, quiet_mark);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* src/cmd_issue_top.sv */
// top of the command issue path; apb regs, two stream generators, arbiter, bus driver
`timescale 1ns/1ps

module cmd_issue_top (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [7:0]                            paddr,
  input  logic [31:0]                           pwdata,
  output logic [31:0]                           prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic                                  cmd_valid,
  output logic [capi_cmd_pkg::cmd_width-1:0]    cmd_command,
  output logic                                  cmd_command_parity,
  output logic [capi_cmd_pkg::addr_width-1:0]   cmd_address,
  output logic                                  cmd_address_parity,
  output logic [capi_cmd_pkg::tag_width-1:0]    cmd_tag,
  output logic                                  cmd_tag_parity,
  output logic [capi_cmd_pkg::size_width-1:0]   cmd_size,
  output logic [capi_cmd_pkg::abt_width-1:0]    cmd_abt,
  output logic [capi_cmd_pkg::ctx_width-1:0]    cmd_context_handle,
  input  logic                                  rsp_valid,
  input  logic [capi_cmd_pkg::tag_width-1:0]    rsp_tag
);

  import capi_cmd_pkg::*;

  logic                     enable;
  logic                     rd_start, wr_start;
  logic [addr_width-1:0]    rd_base, wr_base;
  logic [count_width-1:0]   rd_count, wr_count;
  logic                     rd_busy, wr_busy;
  logic [tag_idx_width:0]   outstanding;
  // generator to arbiter
  logic                     rd_req_valid, rd_req_ready;
  logic [cmd_width-1:0]     rd_req_command;
  logic [addr_width-1:0]    rd_req_address;
  logic [size_width-1:0]    rd_req_size;
  logic                     wr_req_valid, wr_req_ready;
  logic [cmd_width-1:0]     wr_req_command;
  logic [addr_width-1:0]    wr_req_address;
  logic [size_width-1:0]    wr_req_size;
  // arbiter to issue stage
  logic                     grant_valid;
  logic [cmd_width-1:0]     grant_command;
  logic [addr_width-1:0]    grant_address;
  logic [size_width-1:0]    grant_size;
  logic [tag_width-1:0]     grant_tag;

  cmd_apb_regs u_regs (
    .clock, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata,
    .rd_busy, .wr_busy, .outstanding, .prdata, .pready, .pslverr,
    .enable, .rd_start, .wr_start, .rd_base, .rd_count, .wr_base, .wr_count
  );

  cmd_stream_gen #(.cmd_code(cmd_read_cl_na)) u_rd_gen (
    .clock, .rstn, .start(rd_start), .base(rd_base), .count(rd_count),
    .req_ready(rd_req_ready), .req_valid(rd_req_valid), .req_command(rd_req_command),
    .req_address(rd_req_address), .req_size(rd_req_size), .busy(rd_busy)
  );

  cmd_stream_gen #(.cmd_code(cmd_write_na)) u_wr_gen (
    .clock, .rstn, .start(wr_start), .base(wr_base), .count(wr_count),
    .req_ready(wr_req_ready), .req_valid(wr_req_valid), .req_command(wr_req_command),
    .req_address(wr_req_address), .req_size(wr_req_size), .busy(wr_busy)
  );

  cmd_arbiter u_arbiter (
    .clock, .rstn, .enable,
    .rd_req_valid, .rd_req_command, .rd_req_address, .rd_req_size,
    .wr_req_valid, .wr_req_command, .wr_req_address, .wr_req_size,
    .rsp_valid, .rsp_tag, .rd_req_ready, .wr_req_ready,
    .grant_valid, .grant_command, .grant_address, .grant_size, .grant_tag, .outstanding
  );

  cmd_issue u_issue (
    .clock, .rstn, .enable,
    .grant_valid, .grant_command, .grant_address, .grant_size, .grant_tag,
    .cmd_valid, .cmd_command, .cmd_command_parity, .cmd_address, .cmd_address_parity,
    .cmd_tag, .cmd_tag_parity, .cmd_size, .cmd_abt, .cmd_context_handle
  );

endmodule

/* src/cmd_issue.sv */
// host command bus driver; latch stage then output stage with parity, 2 cycles
`timescale 1ns/1ps

module cmd_issue (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  enable,
  input  logic                                  grant_valid,
  input  logic [capi_cmd_pkg::cmd_width-1:0]    grant_command,
  input  logic [capi_cmd_pkg::addr_width-1:0]   grant_address,
  input  logic [capi_cmd_pkg::size_width-1:0]   grant_size,
  input  logic [capi_cmd_pkg::tag_width-1:0]    grant_tag,
  output logic                                  cmd_valid,
  output logic [capi_cmd_pkg::cmd_width-1:0]    cmd_command,
  output logic                                  cmd_command_parity,
  output logic [capi_cmd_pkg::addr_width-1:0]   cmd_address,
  output logic                                  cmd_address_parity,
  output logic [capi_cmd_pkg::tag_width-1:0]    cmd_tag,
  output logic                                  cmd_tag_parity,
  output logic [capi_cmd_pkg::size_width-1:0]   cmd_size,
  output logic [capi_cmd_pkg::abt_width-1:0]    cmd_abt,
  output logic [capi_cmd_pkg::ctx_width-1:0]    cmd_context_handle
);

  import capi_cmd_pkg::*;

  logic                  rstn_q;
  logic                  enabled;
  // latch was loaded on the last edge
  logic                  latch_fresh;
  logic                  latch_valid;
  logic [cmd_width-1:0]  latch_command;
  logic [addr_width-1:0] latch_address;
  logic [size_width-1:0] latch_size;
  logic [tag_width-1:0]  latch_tag;
  logic                  tag_par;
  logic                  command_par;
  logic                  address_par;

  // dedicated mode, strict abort only
  assign cmd_context_handle = '0;
  assign cmd_abt            = abt_strict;

  //////////////////////////////////////////////////////////////////////////
  // reset and enable sync
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rstn_q <= 1'b0;
    end else begin
      rstn_q <= 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rstn_q) begin
    if (!rstn_q) begin
      enabled     <= 1'b0;
      latch_fresh <= 1'b0;
    end else begin
      enabled     <= enable;
      latch_fresh <= enabled;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // latch stage
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn_q) begin
    if (!rstn_q) begin
      latch_valid   <= 1'b0;
      latch_command <= cmd_touch_i;
      latch_address <= '0;
      latch_size    <= '0;
      latch_tag     <= '0;
    end else begin
      // valid holds while disabled
      if (enabled) begin
        latch_valid <= grant_valid;
      end
      latch_command <= grant_command;
      latch_address <= grant_address;
      latch_size    <= grant_size;
      latch_tag     <= grant_tag;
    end
  end

  // odd parity on tag, command and address
  parity #(.bits(tag_width)) u_tag_par (
    .data(latch_tag),
    .odd (1'b1),
    .par (tag_par)
  );

  parity #(.bits(cmd_width)) u_command_par (
    .data(latch_command),
    .odd (1'b1),
    .par (command_par)
  );

  parity #(.bits(addr_width)) u_address_par (
    .data(latch_address),
    .odd (1'b1),
    .par (address_par)
  );

  //////////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn_q) begin
    if (!rstn_q) begin
      cmd_valid   <= 1'b0;
      cmd_command <= cmd_touch_i;
    end else begin
      // a held latch never reissues
      cmd_valid   <= latch_valid & latch_fresh;
      cmd_command <= latch_command;
    end
  end

  always_ff @(posedge clock) begin
    cmd_command_parity <= command_par;
    cmd_address        <= latch_address;
    cmd_address_parity <= address_par;
    cmd_tag            <= latch_tag;
    cmd_tag_parity     <= tag_par;
    cmd_size           <= latch_size;
  end

endmodule

/* src/cmd_arbiter.sv */
// round-robin arbiter between read and write generators with the tag free list
`timescale 1ns/1ps

module cmd_arbiter (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  enable,
  input  logic                                  rd_req_valid,
  input  logic [capi_cmd_pkg::cmd_width-1:0]    rd_req_command,
  input  logic [capi_cmd_pkg::addr_width-1:0]   rd_req_address,
  input  logic [capi_cmd_pkg::size_width-1:0]   rd_req_size,
  input  logic                                  wr_req_valid,
  input  logic [capi_cmd_pkg::cmd_width-1:0]    wr_req_command,
  input  logic [capi_cmd_pkg::addr_width-1:0]   wr_req_address,
  input  logic [capi_cmd_pkg::size_width-1:0]   wr_req_size,
  input  logic                                  rsp_valid,
  input  logic [capi_cmd_pkg::tag_width-1:0]    rsp_tag,
  output logic                                  rd_req_ready,
  output logic                                  wr_req_ready,
  output logic                                  grant_valid,
  output logic [capi_cmd_pkg::cmd_width-1:0]    grant_command,
  output logic [capi_cmd_pkg::addr_width-1:0]   grant_address,
  output logic [capi_cmd_pkg::size_width-1:0]   grant_size,
  output logic [capi_cmd_pkg::tag_width-1:0]    grant_tag,
  output logic [capi_cmd_pkg::tag_idx_width:0]  outstanding
);

  import capi_cmd_pkg::*;

  logic [tag_count-1:0]     free_mask;
  logic [tag_idx_width-1:0] free_idx;
  logic                     can_grant;
  logic                     sel_wr;
  logic                     xfer;
  // last grant went to the write stream
  logic                     last_wr;

  //////////////////////////////////////////////////////////////////////////
  // tag pick and count
  //////////////////////////////////////////////////////////////////////////

  // lowest free tag wins
  always_comb begin
    free_idx = '0;
    for (int i = tag_count - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        free_idx = tag_idx_width'(i);
      end
    end
  end

  always_comb begin
    outstanding = '0;
    for (int i = 0; i < tag_count; i++) begin
      if (!free_mask[i]) begin
        outstanding = outstanding + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // selection
  //////////////////////////////////////////////////////////////////////////

  assign can_grant = enable & (|free_mask);
  // write goes when alone or when read went last
  assign sel_wr       = wr_req_valid & (~rd_req_valid | ~last_wr);
  assign rd_req_ready = can_grant & ~sel_wr;
  assign wr_req_ready = can_grant & sel_wr;
  assign xfer         = can_grant & (rd_req_valid | wr_req_valid);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      grant_valid <= 1'b0;
      last_wr     <= 1'b1;
      free_mask   <= '1;
    end else begin
      grant_valid <= xfer;
      if (xfer) begin
        last_wr <= sel_wr;
      end
      // a response never names the tag taken this cycle
      for (int i = 0; i < tag_count; i++) begin
        if (xfer && free_idx == tag_idx_width'(i)) begin
          free_mask[i] <= 1'b0;
        end else if (rsp_valid && rsp_tag == tag_width'(i)) begin
          free_mask[i] <= 1'b1;
        end
      end
    end
  end

  // grant payload lands one cycle after transfer
  always_ff @(posedge clock) begin
    if (xfer) begin
      grant_command <= sel_wr ? wr_req_command : rd_req_command;
      grant_address <= sel_wr ? wr_req_address : rd_req_address;
      grant_size    <= sel_wr ? wr_req_size : rd_req_size;
      grant_tag     <= tag_width'(free_idx);
    end
  end

endmodule

/* src/cmd_stream_gen.sv */
// cache-line command generator; one instance per stream, offers one command per line
`timescale 1ns/1ps

module cmd_stream_gen #(
  parameter logic [capi_cmd_pkg::cmd_width-1:0] cmd_code = '0
) (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  start,
  input  logic [capi_cmd_pkg::addr_width-1:0]   base,
  input  logic [capi_cmd_pkg::count_width-1:0]  count,
  input  logic                                  req_ready,
  output logic                                  req_valid,
  output logic [capi_cmd_pkg::cmd_width-1:0]    req_command,
  output logic [capi_cmd_pkg::addr_width-1:0]   req_address,
  output logic [capi_cmd_pkg::size_width-1:0]   req_size,
  output logic                                  busy
);

  import capi_cmd_pkg::*;

  logic [count_width-1:0] remaining;
  logic                   xfer;

  // valid for as long as lines remain
  assign req_valid   = busy;
  assign req_command = cmd_code;
  assign req_size    = size_width'(line_bytes);
  assign xfer        = req_valid & req_ready;

  //////////////////////////////////////////////////////////////////////////
  // line walker
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy      <= 1'b0;
      remaining <= '0;
    end else if (!busy) begin
      // start while busy is ignored, zero count does nothing
      if (start && count != '0) begin
        busy      <= 1'b1;
        remaining <= count;
      end
    end else if (xfer) begin
      remaining <= remaining - 1'b1;
      // last line just went out
      if (remaining == count_width'(1)) begin
        busy <= 1'b0;
      end
    end
  end

  // address is payload, loaded on start
  always_ff @(posedge clock) begin
    if (!busy && start) begin
      req_address <= base;
    end else if (xfer) begin
      req_address <= req_address + addr_width'(line_bytes);
    end
  end

endmodule

/* src/cmd_apb_regs.sv */
// apb register block; host programs stream bases and counts, starts streams, reads status
`timescale 1ns/1ps

module cmd_apb_regs (
  input  logic                                      clock,
  input  logic                                      rstn,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  logic [7:0]                                paddr,
  input  logic [31:0]                               pwdata,
  input  logic                                      rd_busy,
  input  logic                                      wr_busy,
  input  logic [capi_cmd_pkg::tag_idx_width:0]      outstanding,
  output logic [31:0]                               prdata,
  output logic                                      pready,
  output logic                                      pslverr,
  output logic                                      enable,
  output logic                                      rd_start,
  output logic                                      wr_start,
  output logic [capi_cmd_pkg::addr_width-1:0]       rd_base,
  output logic [capi_cmd_pkg::count_width-1:0]      rd_count,
  output logic [capi_cmd_pkg::addr_width-1:0]       wr_base,
  output logic [capi_cmd_pkg::count_width-1:0]      wr_count
);

  import capi_cmd_pkg::*;

  logic        access;
  logic        wr_en;
  logic        mapped;
  logic [31:0] rd_word;

  // no wait states
  assign pready = 1'b1;
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  //////////////////////////////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    mapped  = 1'b1;
    rd_word = '0;
    case (paddr)
      reg_ctrl:       rd_word = {31'd0, enable};
      // busy flags live from the generators
      reg_status:     rd_word = {{(24 - tag_idx_width - 1){1'b0}}, outstanding,
                                 6'd0, wr_busy, rd_busy};
      reg_rd_base_lo: rd_word = rd_base[31:0];
      reg_rd_base_hi: rd_word = rd_base[63:32];
      reg_rd_count:   rd_word = {{(32 - count_width){1'b0}}, rd_count};
      reg_wr_base_lo: rd_word = wr_base[31:0];
      reg_wr_base_hi: rd_word = wr_base[63:32];
      reg_wr_count:   rd_word = {{(32 - count_width){1'b0}}, wr_count};
      default:        mapped  = 1'b0;
    endcase
  end

  // unmapped reads come back as zero
  assign prdata  = (access && !pwrite) ? rd_word : 32'd0;
  assign pslverr = access & ~mapped;

  //////////////////////////////////////////////////////////////////////////
  // register writes, taken on the access-phase edge
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enable   <= 1'b0;
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      rd_base  <= '0;
      rd_count <= '0;
      wr_base  <= '0;
      wr_count <= '0;
    end else begin
      // start bits are one-cycle pulses
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      if (wr_en) begin
        case (paddr)
          reg_ctrl: begin
            enable   <= pwdata[0];
            rd_start <= pwdata[1];
            wr_start <= pwdata[2];
          end
          reg_rd_base_lo: rd_base[31:0]  <= pwdata;
          reg_rd_base_hi: rd_base[63:32] <= pwdata;
          reg_rd_count:   rd_count       <= pwdata[count_width-1:0];
          reg_wr_base_lo: wr_base[31:0]  <= pwdata;
          reg_wr_base_hi: wr_base[63:32] <= pwdata;
          reg_wr_count:   wr_count       <= pwdata[count_width-1:0];
          // status is read only, others ignored
          default: ;
        endcase
      end
    end
  end

endmodule

/* src/parity.sv */
// parity bit generator for any width; odd high gives odd parity over data plus par
`timescale 1ns/1ps

module parity #(
  parameter int unsigned bits = 8
) (
  input  logic [bits-1:0] data,
  input  logic            odd,
  output logic            par
);

  // xor reduction is 1 when data already has an odd number of ones
  always_comb begin
    if (odd) begin
      par = ~(^data);
    end else begin
      par = ^data;
    end
  end

endmodule

/* src/capi_cmd_pkg.sv */
// shared constants for the command issue path; imported inside each module body
package capi_cmd_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned cmd_width   = 13;
  localparam int unsigned addr_width  = 64;
  localparam int unsigned tag_width   = 8;
  localparam int unsigned size_width  = 12;
  localparam int unsigned abt_width   = 3;
  localparam int unsigned ctx_width   = 16;
  localparam int unsigned count_width = 16;

  // tag pool, tags 0..15
  localparam int unsigned tag_count     = 16;
  localparam int unsigned tag_idx_width = $clog2(tag_count);

  // one cache line, address step and size field
  localparam int unsigned line_bytes = 128;

  //////////////////////////////////////////////////////////////////////////
  // command codes and abort mode
  //////////////////////////////////////////////////////////////////////////

  localparam logic [cmd_width-1:0] cmd_read_cl_na = 13'h0A00;
  localparam logic [cmd_width-1:0] cmd_write_na   = 13'h0D00;
  // idle value of the command bus
  localparam logic [cmd_width-1:0] cmd_touch_i    = 13'h0240;

  localparam logic [abt_width-1:0] abt_strict = 3'd0;

  //////////////////////////////////////////////////////////////////////////
  // apb register map, byte offsets
  //////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] reg_ctrl       = 8'h00;
  localparam logic [7:0] reg_status     = 8'h04;
  localparam logic [7:0] reg_rd_base_lo = 8'h08;
  localparam logic [7:0] reg_rd_base_hi = 8'h0C;
  localparam logic [7:0] reg_rd_count   = 8'h10;
  localparam logic [7:0] reg_wr_base_lo = 8'h14;
  localparam logic [7:0] reg_wr_base_hi = 8'h18;
  localparam logic [7:0] reg_wr_count   = 8'h1C;

endpackage
